//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_epb_opb_subsys
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- include/epb_opb_settings.svh
`ifndef EPB_OPB_SETTINGS_SVH
`define EPB_OPB_SETTINGS_SVH

// bridge gives up after this many cycles in the wait state
`define EPB_OPB_TIMEOUT_CYCLES 512

// wait states inserted by the register slave before it answers
`define SLAVE_WAIT_CYCLES 3

// slave memory size in 32-bit words
`define SLAVE_DEPTH_WORDS 256

// region codes from OPB address bits 26 to 24 (addr_gp[2:0])
// region 0 is backed by memory
`define REGION_MEM 3'd0
// region 1 answers with an error acknowledge
`define REGION_ERR 3'd1

`endif

//--- logic/epb_capture.sv
`timescale 1ns/1ns

module epb_capture import epb_opb_pkg::*; (
  input  logic        OPB_Clk,
  input  logic        rst_n,
  input  logic        epb_cs_n,
  input  logic        epb_oe_n,
  input  logic        epb_r_w_n,
  input  logic [1:0]  epb_be_n,
  input  logic [22:0] epb_addr,
  input  logic [5:0]  epb_addr_gp,
  input  logic [15:0] epb_data_i,
  output epb_req_t    req,
  output logic        trans_strb
);

  logic        cs_n_q;
  logic        oe_n_q;
  logic        prev_cs_n;
  logic        r_w_n_q;
  logic [1:0]  be_n_q;
  logic [22:0] addr_q;
  logic [5:0]  addr_gp_q;
  logic [15:0] data_q;

  // strobes idle high out of reset so no transfer or drive is seen
  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      cs_n_q    <= 1'b1;
      oe_n_q    <= 1'b1;
      prev_cs_n <= 1'b1;
    end else begin
      cs_n_q    <= epb_cs_n;
      oe_n_q    <= epb_oe_n;
      prev_cs_n <= cs_n_q;
    end
  end

  always_ff @(posedge OPB_Clk) begin
    r_w_n_q   <= epb_r_w_n;
    be_n_q    <= epb_be_n;
    addr_q    <= epb_addr;
    addr_gp_q <= epb_addr_gp;
    data_q    <= epb_data_i;
  end

  // new transaction when registered chip select drops
  assign trans_strb = prev_cs_n & ~cs_n_q;

  assign req.cs_n    = cs_n_q;
  assign req.oe_n    = oe_n_q;
  assign req.r_w_n   = r_w_n_q;
  assign req.be_n    = be_n_q;
  assign req.addr    = addr_q;
  assign req.addr_gp = addr_gp_q;
  assign req.data    = data_q;

endmodule

//--- logic/epb_opb_ctrl.sv
`timescale 1ns/1ns
`include "epb_opb_settings.svh"

module epb_opb_ctrl import epb_opb_pkg::*; (
  input  logic       OPB_Clk,
  input  logic       rst_n,
  input  logic       trans_strb,
  input  opb_reply_t reply,
  output logic       select,
  output logic       done
);

  localparam int CNT_W = $clog2(`EPB_OPB_TIMEOUT_CYCLES + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`EPB_OPB_TIMEOUT_CYCLES);

  bridge_state_e    state;
  logic             select_q;
  logic [CNT_W-1:0] count;
  logic             got_reply;
  logic             timed_out;

  assign got_reply = reply.xfer_ack | reply.err_ack;

  // count holds the number of cycles since the strobe
  assign timed_out = (count == CNT_LAST);

  // finish on a reply or on the last timeout cycle
  assign done = (state == ST_WAIT) && (got_reply || timed_out);

  // cut-through so the slave sees select in the strobe cycle
  assign select = select_q | ((state == ST_IDLE) & trans_strb);

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      select_q <= 1'b0;
      count    <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (trans_strb) begin
            state    <= ST_WAIT;
            select_q <= 1'b1;
            count    <= CNT_W'(1);
          end
        end
        ST_WAIT: begin
          if (done) begin
            state    <= ST_IDLE;
            select_q <= 1'b0;
          end else begin
            count <= count + CNT_W'(1);
          end
        end
        default: begin
          state    <= ST_IDLE;
          select_q <= 1'b0;
        end
      endcase
    end
  end

endmodule

//--- logic/epb_opb_pkg.sv
package epb_opb_pkg;

  // bridge FSM states
  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_WAIT = 1'b1
  } bridge_state_e;

  // EPB pins as seen after the input registers
  typedef struct packed {
    logic        cs_n;
    logic        oe_n;
    logic        r_w_n;
    logic [1:0]  be_n;
    logic [22:0] addr;
    logic [5:0]  addr_gp;
    logic [15:0] data;
  } epb_req_t;

  // OPB master outputs
  // be and dbus are big-endian so be[0] covers dbus[0:7]
  // abus is numbered from the lsb so the region sits in bits 26:24
  typedef struct packed {
    logic        select;
    logic        rnw;
    logic [0:3]  be;
    logic [31:0] abus;
    logic [0:31] dbus;
  } opb_master_t;

  // slave reply with single-cycle acks
  typedef struct packed {
    logic        xfer_ack;
    logic        err_ack;
    logic [0:31] dbus;
  } opb_reply_t;

endpackage

//--- logic/epb_opb_subsys.sv
`timescale 1ns/1ns

module epb_opb_subsys import epb_opb_pkg::*; (
  input  logic        OPB_Clk,
  input  logic        rst_n,
  input  logic        epb_cs_n,
  input  logic        epb_oe_n,
  input  logic        epb_r_w_n,
  input  logic [1:0]  epb_be_n,
  input  logic [22:0] epb_addr,
  input  logic [5:0]  epb_addr_gp,
  input  logic [15:0] epb_data_i,
  output logic [15:0] epb_data_o,
  output logic        epb_rdy,
  output logic        epb_rdy_oe,
  output logic        epb_data_oe_n
);

  epb_req_t    req;
  logic        trans_strb;
  logic        select;
  logic        done;
  opb_master_t master;
  opb_reply_t  reply;

  epb_capture i_epb_capture (
    .OPB_Clk     (OPB_Clk),
    .rst_n       (rst_n),
    .epb_cs_n    (epb_cs_n),
    .epb_oe_n    (epb_oe_n),
    .epb_r_w_n   (epb_r_w_n),
    .epb_be_n    (epb_be_n),
    .epb_addr    (epb_addr),
    .epb_addr_gp (epb_addr_gp),
    .epb_data_i  (epb_data_i),
    .req         (req),
    .trans_strb  (trans_strb)
  );

  epb_opb_ctrl i_epb_opb_ctrl (
    .OPB_Clk    (OPB_Clk),
    .rst_n      (rst_n),
    .trans_strb (trans_strb),
    .reply      (reply),
    .select     (select),
    .done       (done)
  );

  opb_lane_steer i_opb_lane_steer (
    .req    (req),
    .select (select),
    .master (master)
  );

  epb_read_return i_epb_read_return (
    .OPB_Clk       (OPB_Clk),
    .rst_n         (rst_n),
    .req           (req),
    .done          (done),
    .reply         (reply),
    .epb_rdy       (epb_rdy),
    .epb_data_o    (epb_data_o),
    .epb_data_oe_n (epb_data_oe_n)
  );

  opb_sram_slave i_opb_sram_slave (
    .OPB_Clk (OPB_Clk),
    .rst_n   (rst_n),
    .master  (master),
    .reply   (reply)
  );

  // ready pin is driven whenever the host selects us
  assign epb_rdy_oe = ~epb_cs_n;

endmodule

//--- logic/epb_read_return.sv
`timescale 1ns/1ns

module epb_read_return import epb_opb_pkg::*; (
  input  logic        OPB_Clk,
  input  logic        rst_n,
  input  epb_req_t    req,
  input  logic        done,
  input  opb_reply_t  reply,
  output logic        epb_rdy,
  output logic [15:0] epb_data_o,
  output logic        epb_data_oe_n
);

  logic [15:0] halfword;

  assign halfword = req.addr[0] ? reply.dbus[16:31] : reply.dbus[0:15];

  // ready holds until the host releases chip select
  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      epb_rdy <= 1'b0;
    end else if (req.cs_n) begin
      epb_rdy <= 1'b0;
    end else if (done) begin
      epb_rdy <= 1'b1;
    end
  end

  // a timeout keeps the last value
  always_ff @(posedge OPB_Clk) begin
    if (reply.xfer_ack || reply.err_ack) begin
      epb_data_o <= halfword;
    end
  end

  // drive the data pins only for a selected read with oe_n low
  assign epb_data_oe_n = ~req.r_w_n | req.cs_n | req.oe_n;

endmodule

//--- logic/opb_lane_steer.sv
`timescale 1ns/1ns

module opb_lane_steer import epb_opb_pkg::*; (
  input  epb_req_t    req,
  input  logic        select,
  output opb_master_t master
);

  logic low_lane;

  // odd halfword address lands on bytes 2 and 3
  assign low_lane = req.addr[0];

  always_comb begin
    master = '0;
    if (select) begin
      master.select = 1'b1;
      master.rnw    = req.r_w_n;
      // epb addresses halfwords, drop bit 0 and make a byte address
      master.abus   = {5'b0, req.addr_gp[2:0], req.addr[22:1], 2'b00};
      if (req.r_w_n) begin
        // reads fetch the whole halfword of the lane
        if (low_lane) begin
          master.be = 4'b0011;
        end else begin
          master.be = 4'b1100;
        end
        master.dbus = '0;
      end else begin
        // be_n[1] guards the upper byte of the halfword
        if (low_lane) begin
          master.be   = {2'b00, ~req.be_n[1], ~req.be_n[0]};
          master.dbus = {16'h0000, req.data};
        end else begin
          master.be   = {~req.be_n[1], ~req.be_n[0], 2'b00};
          master.dbus = {req.data, 16'h0000};
        end
      end
    end
  end

endmodule

//--- logic/opb_sram_slave.sv
`timescale 1ns/1ns
`include "epb_opb_settings.svh"

module opb_sram_slave import epb_opb_pkg::*; (
  input  logic        OPB_Clk,
  input  logic        rst_n,
  input  opb_master_t master,
  output opb_reply_t  reply
);

  localparam int IDX_W  = $clog2(`SLAVE_DEPTH_WORDS);
  localparam int ANSWER = `SLAVE_WAIT_CYCLES + 1;
  localparam int WCNT_W = $clog2(ANSWER + 2);
  localparam logic [WCNT_W-1:0] WCNT_ANSWER = WCNT_W'(ANSWER);
  localparam logic [WCNT_W-1:0] WCNT_PAST   = WCNT_W'(ANSWER + 1);

  logic [0:31]       mem [`SLAVE_DEPTH_WORDS];
  logic [WCNT_W-1:0] wait_cnt;
  logic [2:0]        region;
  logic [IDX_W-1:0]  word_idx;
  logic              answer_now;
  logic              hit_mem;
  logic              hit_err;

  assign region   = master.abus[26:24];
  assign word_idx = master.abus[IDX_W+1:2];

  // counts cycles since select rose and parks one past the answer so acks stay single
  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      wait_cnt <= '0;
    end else if (!master.select) begin
      wait_cnt <= '0;
    end else if (wait_cnt != WCNT_PAST) begin
      wait_cnt <= wait_cnt + WCNT_W'(1);
    end
  end

  assign answer_now = master.select && (wait_cnt == WCNT_ANSWER);
  assign hit_mem    = answer_now && (region == `REGION_MEM);
  assign hit_err    = answer_now && (region == `REGION_ERR);

  // byte lanes follow be, big-endian like the bus
  always_ff @(posedge OPB_Clk) begin
    if (hit_mem && !master.rnw) begin
      for (int b = 0; b < 4; b++) begin
        if (master.be[b]) begin
          mem[word_idx][b*8 +: 8] <= master.dbus[b*8 +: 8];
        end
      end
    end
  end

  assign reply.xfer_ack = hit_mem;
  assign reply.err_ack  = hit_err;
  // read data only on a read ack and zero otherwise
  assign reply.dbus     = (hit_mem && master.rnw) ? mem[word_idx] : '0;

endmodule

//--- sim.f
+incdir+include
logic/epb_opb_pkg.sv
logic/epb_capture.sv
logic/epb_opb_ctrl.sv
logic/opb_lane_steer.sv
logic/epb_read_return.sv
logic/opb_sram_slave.sv
logic/epb_opb_subsys.sv
verification/tb_epb_opb_subsys.sv

//--- verification/tb_epb_opb_subsys.sv
`timescale 1ns/1ns
`include "epb_opb_settings.svh"

module tb_epb_opb_subsys;

  localparam int N_FIXED = 8;
  localparam int N_WIN   = 16;
  localparam int N_RAND  = 16;
  // oe_n-high read, region 1 and 3 accesses with their region-0 read-backs
  localparam int N_MISC  = 8;
  localparam int N_XFERS = 2 * N_FIXED + 2 * N_WIN + N_RAND + N_MISC;
  localparam int WATCHDOG_CYCLES = 16 + N_XFERS * (`EPB_OPB_TIMEOUT_CYCLES + 20);
  localparam int HW_W    = $clog2(2 * `SLAVE_DEPTH_WORDS);

  localparam logic [2:0] REGION_SILENT = 3'd3;
  localparam logic [8:0] WIN_BASE      = 9'h140;
  // even and odd halfwords at the low and high ends of the slave
  localparam logic [8:0] FIXED_HW [N_FIXED] = '{
    9'h000, 9'h001, 9'h002, 9'h003, 9'h0fe, 9'h0ff, 9'h1fe, 9'h1ff
  };

  logic        OPB_Clk;
  logic        rst_n;
  logic        epb_cs_n;
  logic        epb_oe_n;
  logic        epb_r_w_n;
  logic [1:0]  epb_be_n;
  logic [22:0] epb_addr;
  logic [5:0]  epb_addr_gp;
  logic [15:0] epb_data_i;
  logic [15:0] epb_data_o;
  logic        epb_rdy;
  logic        epb_rdy_oe;
  logic        epb_data_oe_n;

  // halfword view of region 0
  logic [15:0] model_mem [2 * `SLAVE_DEPTH_WORDS];
  logic [15:0] last_read = 16'h0000;
  logic [15:0] exp_q [$];
  logic [15:0] got_q [$];
  logic [31:0] rnd;
  int          n_cmp = 0;

  // pins as the DUT registered them at the last edge
  logic        seen_cs_n  = 1'b1;
  logic        seen_oe_n  = 1'b1;
  logic        seen_r_w_n = 1'b1;

  epb_opb_subsys i_epb_opb_subsys (
    .OPB_Clk       (OPB_Clk),
    .rst_n         (rst_n),
    .epb_cs_n      (epb_cs_n),
    .epb_oe_n      (epb_oe_n),
    .epb_r_w_n     (epb_r_w_n),
    .epb_be_n      (epb_be_n),
    .epb_addr      (epb_addr),
    .epb_addr_gp   (epb_addr_gp),
    .epb_data_i    (epb_data_i),
    .epb_data_o    (epb_data_o),
    .epb_rdy       (epb_rdy),
    .epb_rdy_oe    (epb_rdy_oe),
    .epb_data_oe_n (epb_data_oe_n)
  );

  initial OPB_Clk = 1'b0;
  always #5 OPB_Clk = ~OPB_Clk;

  task automatic compare_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
    if (got !== expected) begin
      $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  // expected read data from the address map
  function automatic logic [15:0] expect_read(input logic [5:0] gp, input logic [22:0] addr);
    logic [2:0] region;
    region = gp[2:0];
    if (region == `REGION_MEM) begin
      return model_mem[addr[HW_W-1:0]];
    end else if (region == `REGION_ERR) begin
      return 16'h0000;
    end
    // silent regions time out and the data latch keeps its value
    return last_read;
  endfunction

  task automatic model_write(input logic [5:0] gp, input logic [22:0] addr,
                             input logic [1:0] be_n, input logic [15:0] data);
    if (gp[2:0] == `REGION_MEM) begin
      if (!be_n[1]) begin
        model_mem[addr[HW_W-1:0]][15:8] = data[15:8];
      end
      if (!be_n[0]) begin
        model_mem[addr[HW_W-1:0]][7:0] = data[7:0];
      end
    end
  endtask

  // bits above the slave index are ignored by the bus, so fill them randomly
  function automatic logic [22:0] with_upper_bits(input logic [8:0] hw);
    logic [31:0] r;
    r = $urandom;
    return {r[13:0], hw};
  endfunction

  function automatic logic [5:0] gp_for_region(input logic [2:0] region);
    logic [31:0] r;
    r = $urandom;
    return {r[2:0], region};
  endfunction

  task automatic wait_ready();
    @(posedge OPB_Clk);
    #1;
    while (!epb_rdy) begin
      @(posedge OPB_Clk);
      #1;
    end
  endtask

  task automatic release_bus();
    epb_cs_n  = 1'b1;
    epb_oe_n  = 1'b1;
    epb_r_w_n = 1'b1;
    epb_be_n  = 2'b11;
    repeat (2) begin
      @(posedge OPB_Clk);
      #1;
    end
  endtask

  task automatic epb_write(input logic [5:0] gp, input logic [22:0] addr,
                           input logic [1:0] be_n, input logic [15:0] data);
    @(posedge OPB_Clk);
    #1;
    epb_addr_gp = gp;
    epb_addr    = addr;
    epb_be_n    = be_n;
    epb_data_i  = data;
    epb_r_w_n   = 1'b0;
    epb_cs_n    = 1'b0;
    wait_ready();
    model_write(gp, addr, be_n, data);
    release_bus();
  endtask

  task automatic epb_read(input logic [5:0] gp, input logic [22:0] addr, input logic oe_n);
    logic [15:0] expected;
    expected = expect_read(gp, addr);
    @(posedge OPB_Clk);
    #1;
    epb_addr_gp = gp;
    epb_addr    = addr;
    epb_be_n    = 2'b00;
    epb_r_w_n   = 1'b1;
    epb_oe_n    = oe_n;
    epb_cs_n    = 1'b0;
    wait_ready();
    exp_q.push_back(expected);
    got_q.push_back(epb_data_o);
    last_read = expected;
    release_bus();
  endtask

  always @(posedge OPB_Clk) begin
    seen_cs_n  <= epb_cs_n;
    seen_oe_n  <= epb_oe_n;
    seen_r_w_n <= epb_r_w_n;
  end

  // pin checks and read data comparison on the falling edge
  always @(negedge OPB_Clk) begin
    compare_value(32'(epb_rdy_oe), 32'(!epb_cs_n), "epb_rdy_oe");
    compare_value(32'(epb_data_oe_n), 32'(!(seen_r_w_n & ~seen_cs_n & ~seen_oe_n)),
                  "epb_data_oe_n");
    while (got_q.size() > 0) begin
      n_cmp++;
      compare_value(32'(got_q.pop_front()), 32'(exp_q.pop_front()),
                    $sformatf("read %0d data", n_cmp));
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge OPB_Clk);
    $display("watchdog expired, a transfer never got epb_rdy");
    $display("TESTBENCH FAILED");
    $fatal(1);
  end

  initial begin : stimulus
    logic [8:0] hw;
    logic [1:0] be_n;
    // seed the generator once
    rnd = $urandom(32'h9635);
    rst_n       = 1'b0;
    epb_cs_n    = 1'b1;
    epb_oe_n    = 1'b1;
    epb_r_w_n   = 1'b1;
    epb_be_n    = 2'b11;
    epb_addr    = '0;
    epb_addr_gp = '0;
    epb_data_i  = '0;
    repeat (16) @(posedge OPB_Clk);
    #1;
    rst_n = 1'b1;

    // idle bus after reset
    repeat (4) begin
      @(posedge OPB_Clk);
      #1;
      compare_value(32'(epb_rdy), 32'd0, "epb_rdy with chip select high");
      compare_value(32'(epb_data_oe_n), 32'd1, "epb_data_oe_n with chip select high");
    end

    // full halfwords on both lanes
    for (int i = 0; i < N_FIXED; i++) begin
      rnd = $urandom;
      epb_write(gp_for_region(`REGION_MEM), with_upper_bits(FIXED_HW[i]), 2'b00, rnd[15:0]);
    end
    for (int i = 0; i < N_FIXED; i++) begin
      epb_read(gp_for_region(`REGION_MEM), with_upper_bits(FIXED_HW[i]), 1'b0);
    end

    // single byte writes into a known window
    for (int i = 0; i < N_WIN; i++) begin
      rnd = $urandom;
      epb_write(gp_for_region(`REGION_MEM), with_upper_bits(WIN_BASE + 9'(i)), 2'b00, rnd[15:0]);
    end
    for (int i = 0; i < N_RAND; i++) begin
      rnd  = $urandom;
      hw   = WIN_BASE + {5'd0, rnd[19:16]};
      be_n = rnd[20] ? 2'b01 : 2'b10;
      epb_write(gp_for_region(`REGION_MEM), with_upper_bits(hw), be_n, rnd[15:0]);
    end
    for (int i = 0; i < N_WIN; i++) begin
      epb_read(gp_for_region(`REGION_MEM), with_upper_bits(WIN_BASE + 9'(i)), 1'b0);
    end

    // read with oe_n high keeps the data pins released
    epb_read(gp_for_region(`REGION_MEM), with_upper_bits(FIXED_HW[0]), 1'b1);

    // error region, then writes that must not reach region 0
    epb_read(gp_for_region(`REGION_ERR), with_upper_bits(FIXED_HW[4]), 1'b0);
    epb_write(gp_for_region(`REGION_ERR), with_upper_bits(FIXED_HW[2]), 2'b00, 16'hdead);
    epb_write(gp_for_region(REGION_SILENT), with_upper_bits(FIXED_HW[3]), 2'b00, 16'hbeef);
    epb_read(gp_for_region(`REGION_MEM), with_upper_bits(FIXED_HW[2]), 1'b0);
    epb_read(gp_for_region(`REGION_MEM), with_upper_bits(FIXED_HW[3]), 1'b0);

    // timeout read returns the previous read value
    epb_read(gp_for_region(`REGION_MEM), with_upper_bits(FIXED_HW[5]), 1'b0);
    epb_read(gp_for_region(REGION_SILENT), with_upper_bits(FIXED_HW[6]), 1'b0);

    repeat (2) @(negedge OPB_Clk);
    if (got_q.size() != 0) begin
      $display("some reads were never compared before the end of the run");
      $display("TESTBENCH FAILED");
      $fatal(1);
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule
